// File: rtl/fetch_pkg.sv
// fetch path widths, parcel buffer depth default
// and the fetch word struct
package fetch_pkg;

  // instruction and pc width
  parameter int XLEN = 32;

  // one compressed parcel
  parameter int PARCEL_W = 16;

  // default depth of the realign buffer in parcels
  parameter int BUF_PARCELS_DEF = 4;

  // word from the icache together with its word-aligned pc
  typedef struct packed {
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] pc;
  } fetch_word_s;

endpackage

// File: rtl/rv_isa_pkg.sv
// rv32i major opcodes, funct3/funct7 values
// and the instruction format union
package rv_isa_pkg;

  parameter logic [6:0] OPCODE_LOAD   = 7'h03;
  parameter logic [6:0] OPCODE_OP_IMM = 7'h13;
  parameter logic [6:0] OPCODE_STORE  = 7'h23;
  parameter logic [6:0] OPCODE_OP     = 7'h33;
  parameter logic [6:0] OPCODE_LUI    = 7'h37;
  parameter logic [6:0] OPCODE_BRANCH = 7'h63;
  parameter logic [6:0] OPCODE_JALR   = 7'h67;
  parameter logic [6:0] OPCODE_JAL    = 7'h6f;

  parameter logic [2:0] F3_ADD = 3'b000;
  parameter logic [2:0] F3_SLL = 3'b001;
  parameter logic [2:0] F3_W   = 3'b010;
  parameter logic [2:0] F3_XOR = 3'b100;
  parameter logic [2:0] F3_SR  = 3'b101;
  parameter logic [2:0] F3_OR  = 3'b110;
  parameter logic [2:0] F3_AND = 3'b111;
  parameter logic [2:0] F3_BEQ = 3'b000;
  parameter logic [2:0] F3_BNE = 3'b001;

  // sub and sra select
  parameter logic [6:0] F7_SUB = 7'b0100000;

  parameter logic [31:0] EBREAK_INSTR = 32'h0010_0073;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_s;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_s;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_s;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_s;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_s;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_s;

  // one instruction word, seen through each base format
  typedef union packed {
    logic [31:0] raw;
    r_type_s     r;
    i_type_s     i;
    s_type_s     s;
    b_type_s     b;
    u_type_s     u;
    j_type_s     j;
  } instr32_u;

endpackage

// File: rtl/parcel_if.sv
// assembled instruction handed from the realigner
// through the decompressor to the output register
interface parcel_if;

  logic                       valid;
  rv_isa_pkg::instr32_u       instr;
  logic [fetch_pkg::XLEN-1:0] pc;

  // filled in by the decompressor
  rv_isa_pkg::instr32_u       xinstr;
  logic                       comp;
  logic                       illegal;

  modport realign (
    output valid, instr, pc
  );

  modport dcmp (
    input  valid, instr, pc,
    output xinstr, comp, illegal
  );

  modport sink (
    input valid, instr, pc, xinstr, comp, illegal
  );

endinterface

// File: rtl/fetch_realign.sv
// parcel buffer that assembles rv32ic instructions from fetch words,
// tracks the head pc and flushes on redirect
module fetch_realign #(
  parameter int BUF_PARCELS = fetch_pkg::BUF_PARCELS_DEF
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::XLEN-1:0] fetch_data,
  input  logic [fetch_pkg::XLEN-1:0] fetch_pc,
  input  logic                       fetch_ack,
  input  logic                       req_kill,
  input  logic [fetch_pkg::XLEN-1:0] kill_pc,
  output logic                       fetch_req,
  parcel_if.realign                  out
);

  localparam int PTR_W = $clog2(BUF_PARCELS);
  localparam int CNT_W = $clog2(BUF_PARCELS + 1);
  localparam logic [PTR_W:0]   DEPTH   = (PTR_W + 1)'(BUF_PARCELS);
  // room for one more word means two free parcels
  localparam logic [CNT_W-1:0] REQ_MAX = CNT_W'(BUF_PARCELS - 2);

  logic [fetch_pkg::PARCEL_W-1:0] parcel_buf [BUF_PARCELS];
  logic [PTR_W-1:0]               rd_ptr;
  logic [PTR_W-1:0]               wr_ptr;
  logic [CNT_W-1:0]               count_q;
  logic [fetch_pkg::XLEN-1:0]     head_pc;
  logic                           pc_load;

  fetch_pkg::fetch_word_s fw;
  rv_isa_pkg::instr32_u   head_word;
  logic [1:0]             need_n;
  logic [1:0]             pop_n;
  logic [1:0]             push_n;
  logic                   push;
  logic                   drop_low;
  logic                   head_ready;
  logic [fetch_pkg::XLEN-1:0] pc_step;

  // circular pointer advance, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p,
                                               input logic [1:0]       n);
    logic [PTR_W:0] sum;
    sum = {1'b0, p} + {{(PTR_W - 1){1'b0}}, n};
    if (sum >= DEPTH) begin
      sum = sum - DEPTH;
    end
    return sum[PTR_W-1:0];
  endfunction

  assign fw.data = fetch_data;
  assign fw.pc   = fetch_pc;

  // head parcel plus the one behind it, upper half only matters for 32-bit
  assign head_word.raw = {parcel_buf[ptr_add(rd_ptr, 2'd1)], parcel_buf[rd_ptr]};
  assign need_n        = (head_word.raw[1:0] == 2'b11) ? 2'd2 : 2'd1;
  assign head_ready    = count_q >= {{(CNT_W - 2){1'b0}}, need_n};

  assign out.valid = head_ready && !req_kill;
  assign out.instr = head_word;
  assign out.pc    = head_pc;

  assign pop_n   = out.valid ? need_n : 2'd0;
  assign pc_step = {{(fetch_pkg::XLEN - 3){1'b0}}, pop_n, 1'b0};

  // first word after a redirect to an odd parcel carries a stale low half
  assign drop_low = (count_q == '0) && (pc_load ? fw.pc[1] : head_pc[1]);
  assign push     = fetch_ack && !req_kill;
  assign push_n   = !push ? 2'd0 : (drop_low ? 2'd1 : 2'd2);

  assign fetch_req = count_q <= REQ_MAX;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count_q <= '0;
      head_pc <= '0;
      pc_load <= 1'b1;
    end else if (req_kill) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count_q <= '0;
      head_pc <= kill_pc;
      pc_load <= 1'b0;
    end else begin
      rd_ptr  <= ptr_add(rd_ptr, pop_n);
      wr_ptr  <= ptr_add(wr_ptr, push_n);
      count_q <= count_q + {{(CNT_W - 2){1'b0}}, push_n}
                         - {{(CNT_W - 2){1'b0}}, pop_n};
      // buffer is empty here, so nothing pops in the same cycle
      if (push && pc_load) begin
        head_pc <= fw.pc;
        pc_load <= 1'b0;
      end else begin
        head_pc <= head_pc + pc_step;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      if (drop_low) begin
        parcel_buf[wr_ptr] <= fw.data[fetch_pkg::XLEN-1:fetch_pkg::PARCEL_W];
      end else begin
        parcel_buf[wr_ptr]                <= fw.data[fetch_pkg::PARCEL_W-1:0];
        parcel_buf[ptr_add(wr_ptr, 2'd1)] <= fw.data[fetch_pkg::XLEN-1:fetch_pkg::PARCEL_W];
      end
    end
  end

endmodule

// File: rtl/rvc_decompress.sv
// combinational rvc to rv32i expansion, flags compressed
// input and the reserved c0 encoding
module rvc_decompress (
  parcel_if.dcmp ifc
);

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  logic [15:0]          c;
  logic [4:0]           rd_full;
  logic [4:0]           rs2_full;
  // three-bit register fields map onto x8..x15
  logic [4:0]           rdp;
  logic [4:0]           rs1p;
  logic [11:0]          imm6;
  logic [2:0]           f3_alu;
  logic                 reserved;
  rv_isa_pkg::instr32_u x;

  assign c        = ifc.instr.raw[15:0];
  assign rd_full  = c[11:7];
  assign rs2_full = c[6:2];
  assign rdp      = {2'b01, c[4:2]};
  assign rs1p     = {2'b01, c[9:7]};
  assign imm6     = {{6{c[12]}}, c[12], c[6:2]};

  // c.sub/xor/or/and select
  always_comb begin
    unique case (c[6:5])
      2'b00:   f3_alu = rv_isa_pkg::F3_ADD;
      2'b01:   f3_alu = rv_isa_pkg::F3_XOR;
      2'b10:   f3_alu = rv_isa_pkg::F3_OR;
      default: f3_alu = rv_isa_pkg::F3_AND;
    endcase
  end

  always_comb begin
    x        = ifc.instr;
    reserved = 1'b0;
    unique case (c[1:0])
      // quadrant 0
      2'b00: begin
        unique case (c[15:14])
          2'b00: begin
            // c.addi4spn -> addi rd', x2, nzuimm
            x.i = '{imm: {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00}, rs1: REG_SP,
                    funct3: rv_isa_pkg::F3_ADD, rd: rdp, opcode: rv_isa_pkg::OPCODE_OP_IMM};
          end
          2'b01: begin
            // c.lw
            x.i = '{imm: {5'b0, c[5], c[12:10], c[6], 2'b00}, rs1: rs1p,
                    funct3: rv_isa_pkg::F3_W, rd: rdp, opcode: rv_isa_pkg::OPCODE_LOAD};
          end
          2'b11: begin
            // c.sw
            x.s = '{imm_hi: {5'b0, c[5], c[12]}, rs2: rdp, rs1: rs1p,
                    funct3: rv_isa_pkg::F3_W, imm_lo: {c[11:10], c[6], 2'b00},
                    opcode: rv_isa_pkg::OPCODE_STORE};
          end
          default: reserved = 1'b1;
        endcase
      end

      // quadrant 1
      2'b01: begin
        unique case (c[15:13])
          3'b000: begin
            // c.addi, c.nop
            x.i = '{imm: imm6, rs1: rd_full, funct3: rv_isa_pkg::F3_ADD, rd: rd_full,
                    opcode: rv_isa_pkg::OPCODE_OP_IMM};
          end
          3'b001, 3'b101: begin
            // c.jal links to x1, c.j to x0
            x.j = '{imm20: c[12], imm10_1: {c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3]},
                    imm11: c[12], imm19_12: {8{c[12]}}, rd: {4'b0, ~c[15]},
                    opcode: rv_isa_pkg::OPCODE_JAL};
          end
          3'b010: begin
            // c.li
            x.i = '{imm: imm6, rs1: REG_ZERO, funct3: rv_isa_pkg::F3_ADD, rd: rd_full,
                    opcode: rv_isa_pkg::OPCODE_OP_IMM};
          end
          3'b011: begin
            if (rd_full == REG_SP) begin
              // c.addi16sp
              x.i = '{imm: {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0}, rs1: REG_SP,
                      funct3: rv_isa_pkg::F3_ADD, rd: REG_SP,
                      opcode: rv_isa_pkg::OPCODE_OP_IMM};
            end else begin
              // c.lui
              x.u = '{imm: {{15{c[12]}}, c[6:2]}, rd: rd_full, opcode: rv_isa_pkg::OPCODE_LUI};
            end
          end
          3'b100: begin
            unique case (c[11:10])
              2'b00, 2'b01: begin
                // c.srli, c.srai share funct3, bit 10 picks arithmetic
                x.i = '{imm: {1'b0, c[10], 5'b0, c[6:2]}, rs1: rs1p,
                        funct3: rv_isa_pkg::F3_SR, rd: rs1p,
                        opcode: rv_isa_pkg::OPCODE_OP_IMM};
              end
              2'b10: begin
                // c.andi
                x.i = '{imm: imm6, rs1: rs1p, funct3: rv_isa_pkg::F3_AND, rd: rs1p,
                        opcode: rv_isa_pkg::OPCODE_OP_IMM};
              end
              default: begin
                x.r = '{funct7: (c[6:5] == 2'b00) ? rv_isa_pkg::F7_SUB : 7'b0,
                        rs2: rdp, rs1: rs1p, funct3: f3_alu, rd: rs1p,
                        opcode: rv_isa_pkg::OPCODE_OP};
              end
            endcase
          end
          default: begin
            // c.beqz / c.bnez, bit 13 selects bne
            x.b = '{imm12: c[12], imm10_5: {{3{c[12]}}, c[6:5], c[2]}, rs2: REG_ZERO,
                    rs1: rs1p, funct3: c[13] ? rv_isa_pkg::F3_BNE : rv_isa_pkg::F3_BEQ,
                    imm4_1: {c[11:10], c[4:3]}, imm11: c[12],
                    opcode: rv_isa_pkg::OPCODE_BRANCH};
          end
        endcase
      end

      // quadrant 2
      2'b10: begin
        unique case (c[15:14])
          2'b00: begin
            // c.slli
            x.i = '{imm: {7'b0, c[6:2]}, rs1: rd_full, funct3: rv_isa_pkg::F3_SLL,
                    rd: rd_full, opcode: rv_isa_pkg::OPCODE_OP_IMM};
          end
          2'b01: begin
            // c.lwsp
            x.i = '{imm: {4'b0, c[3:2], c[12], c[6:4], 2'b00}, rs1: REG_SP,
                    funct3: rv_isa_pkg::F3_W, rd: rd_full, opcode: rv_isa_pkg::OPCODE_LOAD};
          end
          2'b10: begin
            if (rs2_full != REG_ZERO) begin
              // c.mv reads x0, c.add reads rd
              x.r = '{funct7: 7'b0, rs2: rs2_full, rs1: c[12] ? rd_full : REG_ZERO,
                      funct3: rv_isa_pkg::F3_ADD, rd: rd_full, opcode: rv_isa_pkg::OPCODE_OP};
            end else if (c[12] && (rd_full == REG_ZERO)) begin
              x.raw = rv_isa_pkg::EBREAK_INSTR;
            end else begin
              // c.jr links to x0, c.jalr to x1
              x.i = '{imm: 12'b0, rs1: rd_full, funct3: 3'b000,
                      rd: c[12] ? REG_RA : REG_ZERO, opcode: rv_isa_pkg::OPCODE_JALR};
            end
          end
          default: begin
            // c.swsp
            x.s = '{imm_hi: {4'b0, c[8:7], c[12]}, rs2: rs2_full, rs1: REG_SP,
                    funct3: rv_isa_pkg::F3_W, imm_lo: {c[11:9], 2'b00},
                    opcode: rv_isa_pkg::OPCODE_STORE};
          end
        endcase
      end

      // full-width instruction goes through as it is
      default: x = ifc.instr;
    endcase
  end

  assign ifc.xinstr  = x;
  assign ifc.comp    = c[1:0] != 2'b11;
  assign ifc.illegal = reserved;

endmodule

// File: rtl/fetch_out_reg.sv
// output register toward decode and sequential next-pc
module fetch_out_reg (
  input  logic                       clk,
  input  logic                       rst_n,
  parcel_if.sink                     in,
  output logic [fetch_pkg::XLEN-1:0] instr,
  output logic [fetch_pkg::XLEN-1:0] instr_pc,
  output logic [fetch_pkg::XLEN-1:0] instr_next_pc,
  output logic                       instr_valid,
  output logic                       instr_comp,
  output logic                       instr_illegal
);

  localparam logic [fetch_pkg::XLEN-1:0] STEP_C = 'd2;
  localparam logic [fetch_pkg::XLEN-1:0] STEP_W = 'd4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= in.valid;
    end
  end

  // payload only moves with a valid instruction
  always_ff @(posedge clk) begin
    if (in.valid) begin
      instr         <= in.xinstr.raw;
      instr_pc      <= in.pc;
      instr_comp    <= in.comp;
      instr_illegal <= in.illegal;
    end
  end

  assign instr_next_pc = instr_pc + (instr_comp ? STEP_C : STEP_W);

endmodule

// File: rtl/fetch_align_top.sv
// fetch alignment path: realigner, rvc expander
// and output register
module fetch_align_top #(
  parameter int BUF_PARCELS = fetch_pkg::BUF_PARCELS_DEF
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::XLEN-1:0] fetch_data,
  input  logic [fetch_pkg::XLEN-1:0] fetch_pc,
  input  logic                       fetch_ack,
  input  logic                       req_kill,
  input  logic [fetch_pkg::XLEN-1:0] kill_pc,
  output logic                       fetch_req,
  output logic [fetch_pkg::XLEN-1:0] instr,
  output logic [fetch_pkg::XLEN-1:0] instr_pc,
  output logic [fetch_pkg::XLEN-1:0] instr_next_pc,
  output logic                       instr_valid,
  output logic                       instr_comp,
  output logic                       instr_illegal
);

  parcel_if pif ();

  fetch_realign #(
    .BUF_PARCELS(BUF_PARCELS)
  ) u_fetch_realign (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch_data(fetch_data),
    .fetch_pc  (fetch_pc),
    .fetch_ack (fetch_ack),
    .req_kill  (req_kill),
    .kill_pc   (kill_pc),
    .fetch_req (fetch_req),
    .out       (pif.realign)
  );

  rvc_decompress u_rvc_decompress (
    .ifc(pif.dcmp)
  );

  fetch_out_reg u_fetch_out_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .in           (pif.sink),
    .instr        (instr),
    .instr_pc     (instr_pc),
    .instr_next_pc(instr_next_pc),
    .instr_valid  (instr_valid),
    .instr_comp   (instr_comp),
    .instr_illegal(instr_illegal)
  );

endmodule

// File: include/tb_vectors.svh
// stimulus words, redirects and expected instructions
// for the fetch alignment testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  fetch_pkg::fetch_word_s word;
  logic                   kill;
  logic [31:0]            kill_pc;
} stim_s;

typedef struct packed {
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] next_pc;
  logic        comp;
  logic        illegal;
} exp_s;

stim_s stim_q[$];
exp_s  exp_q[$];
string name_q[$];

task automatic push_word(input logic [31:0] data, input logic [31:0] pc);
  stim_q.push_back('{word: '{data: data, pc: pc}, kill: 1'b0, kill_pc: 32'h0});
endtask

task automatic redirect(input logic [31:0] kpc);
  stim_q.push_back('{word: '0, kill: 1'b1, kill_pc: kpc});
endtask

// next pc follows from the instruction length
task automatic expect_instr(input string name, input logic [31:0] instr, input logic [31:0] pc,
                            input logic comp, input logic illegal);
  exp_s e;
  e.instr   = instr;
  e.pc      = pc;
  e.next_pc = pc + (comp ? 32'd2 : 32'd4);
  e.comp    = comp;
  e.illegal = illegal;
  exp_q.push_back(e);
  name_q.push_back(name);
endtask

// one word holding two compressed instructions
task automatic rvc_pair(input string name, input logic [31:0] data, input logic [31:0] pc,
                        input logic [31:0] lo, input logic [31:0] hi);
  push_word(data, pc);
  expect_instr({name, " lo"}, lo, pc, 1'b1, 1'b0);
  expect_instr({name, " hi"}, hi, pc + 32'd2, 1'b1, 1'b0);
endtask

task automatic load_vectors();
  push_word(32'h0050_0093, 32'h100);
  expect_instr("addi 32", 32'h0050_0093, 32'h100, 1'b0, 1'b0);
  push_word(32'h0020_81b3, 32'h104);
  expect_instr("add 32", 32'h0020_81b3, 32'h104, 1'b0, 1'b0);
  rvc_pair("c.addi c.li", 32'h557d_040d, 32'h108, 32'h0034_0413, 32'hfff0_0513);
  rvc_pair("c.lw c.sw", 32'hc504_4144, 32'h10c, 32'h0045_2483, 32'h0095_2423);
  rvc_pair("c.addi4spn c.lwsp", 32'h45b2_0800, 32'h110, 32'h0101_0413, 32'h00c1_2583);
  rvc_pair("c.swsp c.slli", 32'h060e_ca2e, 32'h114, 32'h00b1_2a23, 32'h0036_1613);
  rvc_pair("c.lui c.addi16sp", 32'h6105_6695, 32'h118, 32'h0000_56b7, 32'h0201_0113);
  rvc_pair("c.srli c.srai", 32'h8491_8009, 32'h11c, 32'h0024_5413, 32'h4044_d493);
  rvc_pair("c.andi c.sub", 32'h8c05_9979, 32'h120, 32'hffe5_7513, 32'h4094_0433);
  rvc_pair("c.xor c.or", 32'h8e55_8db1, 32'h124, 32'h00c5_c5b3, 32'h00d6_6633);
  rvc_pair("c.and c.mv", 32'h873e_8ef9, 32'h128, 32'h00e6_f6b3, 32'h00f0_0733);
  rvc_pair("c.add c.ebreak", 32'h9002_929a, 32'h12c, 32'h0062_82b3, 32'h0010_0073);
  rvc_pair("c.jr c.jalr", 32'h9282_8082, 32'h130, 32'h0000_8067, 32'h0002_80e7);
  rvc_pair("c.j c.jal", 32'h3ff5_a021, 32'h134, 32'h0080_006f, 32'hffdf_f0ef);
  rvc_pair("c.beqz c.bnez", 32'hfcfd_c019, 32'h138, 32'h0004_0363, 32'hfe04_9fe3);
  // lw x20 split over two words
  push_word(32'haa03_0001, 32'h13c);
  expect_instr("c.nop before split", 32'h0000_0013, 32'h13c, 1'b1, 1'b0);
  expect_instr("split lw", 32'h010a_aa03, 32'h13e, 1'b0, 1'b0);
  push_word(32'h0001_010a, 32'h140);
  expect_instr("c.nop after split", 32'h0000_0013, 32'h142, 1'b1, 1'b0);
  // reserved c0 leaves the word raw
  push_word(32'h040d_8000, 32'h144);
  expect_instr("reserved c0", 32'h040d_8000, 32'h144, 1'b1, 1'b1);
  expect_instr("c.addi after reserved", 32'h0034_0413, 32'h146, 1'b1, 1'b0);
  // low half of a full-width instruction is left behind and flushed
  push_word(32'haa03_0001, 32'h148);
  expect_instr("c.nop before kill", 32'h0000_0013, 32'h148, 1'b1, 1'b0);
  redirect(32'h202);
  push_word(32'h557d_beef, 32'h200);
  expect_instr("c.li at odd kill pc", 32'hfff0_0513, 32'h202, 1'b1, 1'b0);
  push_word(32'h0020_81b3, 32'h204);
  expect_instr("add after kill", 32'h0020_81b3, 32'h204, 1'b0, 1'b0);
  redirect(32'h300);
  push_word(32'h0050_0093, 32'h300);
  expect_instr("addi at kill pc", 32'h0050_0093, 32'h300, 1'b0, 1'b0);
endtask

`endif

// File: dv/tb_fetch_align.sv
// fetch alignment testbench with clock, reset, table-driven stimulus
// with random idle gaps, output monitor and timeout
module tb_fetch_align;

  logic        clk;
  logic        rst_n;
  logic [31:0] fetch_data;
  logic [31:0] fetch_pc;
  logic        fetch_ack;
  logic        req_kill;
  logic [31:0] kill_pc;
  logic        fetch_req;
  logic [31:0] instr;
  logic [31:0] instr_pc;
  logic [31:0] instr_next_pc;
  logic        instr_valid;
  logic        instr_comp;
  logic        instr_illegal;

  int          cycles = 0;
  int          cycle_limit = 1000;
  logic [7:0]  lfsr = 8'd28;

  `include "tb_vectors.svh"

  fetch_align_top #(
    .BUF_PARCELS(fetch_pkg::BUF_PARCELS_DEF)
  ) u_fetch_align_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_data   (fetch_data),
    .fetch_pc     (fetch_pc),
    .fetch_ack    (fetch_ack),
    .req_kill     (req_kill),
    .kill_pc      (kill_pc),
    .fetch_req    (fetch_req),
    .instr        (instr),
    .instr_pc     (instr_pc),
    .instr_next_pc(instr_next_pc),
    .instr_valid  (instr_valid),
    .instr_comp   (instr_comp),
    .instr_illegal(instr_illegal)
  );

  always #50 clk = ~clk;

  // taps 8,6,5,4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped producing instructions", cycles);
      $display("Regression failed");
      $fatal(1);
    end
  end

  // each registered instruction against the next expected entry
  always @(negedge clk) begin
    exp_s  e;
    string n;
    if (rst_n && instr_valid) begin
      if (exp_q.size() == 0) begin
        $display("instruction %h at pc %h was not expected", instr, instr_pc);
        $display("Regression failed");
        $fatal(1);
      end else begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        compare({n, " instr"}, e.instr, instr);
        compare({n, " pc"}, e.pc, instr_pc);
        compare({n, " next_pc"}, e.next_pc, instr_next_pc);
        compare({n, " comp"}, {31'b0, e.comp}, {31'b0, instr_comp});
        compare({n, " illegal"}, {31'b0, e.illegal}, {31'b0, instr_illegal});
      end
    end
  end

  initial begin
    logic [1:0] idle;
    clk        = 1'b0;
    rst_n      = 1'b0;
    fetch_data = '0;
    fetch_pc   = '0;
    fetch_ack  = 1'b0;
    req_kill   = 1'b0;
    kill_pc    = '0;
    load_vectors();
    cycle_limit = 10 + 20 * stim_q.size();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare("reset instr_valid", 32'd0, {31'b0, instr_valid});
    compare("reset fetch_req", 32'd1, {31'b0, fetch_req});
    for (int i = 0; i < stim_q.size(); i++) begin
      idle = '0;
      repeat (2) begin
        lfsr = lfsr_step(lfsr);
        idle = {idle[0], lfsr[0]};
      end
      repeat (idle) @(posedge clk);
      @(negedge clk);
      while (!fetch_req) @(negedge clk);
      @(posedge clk);
      if (stim_q[i].kill) begin
        req_kill <= 1'b1;
        kill_pc  <= stim_q[i].kill_pc;
      end else begin
        fetch_ack  <= 1'b1;
        fetch_data <= stim_q[i].word.data;
        fetch_pc   <= stim_q[i].word.pc;
      end
      @(posedge clk);
      fetch_ack <= 1'b0;
      req_kill  <= 1'b0;
    end
    while (exp_q.size() != 0) @(negedge clk);
    // a few more cycles to catch stray outputs
    repeat (4) @(negedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
rtl/fetch_pkg.sv
rtl/rv_isa_pkg.sv
rtl/parcel_if.sv
rtl/fetch_realign.sv
rtl/rvc_decompress.sv
rtl/fetch_out_reg.sv
rtl/fetch_align_top.sv
dv/tb_fetch_align.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch alignment testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fetch_align \
  -f vlog.f --Mdir obj_dir -o sim_fetch_align
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_fetch_align > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression passed" sim.log; then
  exit 0
fi
exit 1
